/* Makefile */
# Verilator build and run for the UDP receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_rx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/udp_hdr_capture.sv */
// udp_hdr_capture: IP header register and byte-wise UDP header assembly
`timescale 1ns/1ps

module udp_hdr_capture (
    input  logic                       clk,

    input  udp_rx_pkg::ip_hdr_t        s_hdr,
    input  logic                       hdr_store,

    input  udp_rx_pkg::byte_t          data,
    input  logic                       udp_byte_store,
    input  udp_rx_pkg::hdr_ptr_t       udp_byte_ptr,

    output udp_rx_pkg::udp_frame_hdr_t frame_hdr
);

    // even pointer is the high byte, network order
    logic hi_byte;

    assign hi_byte = !udp_byte_ptr[0];

    always_ff @(posedge clk) begin
        if (hdr_store) begin
            frame_hdr.ip <= s_hdr;
        end

        if (udp_byte_store) begin
            // upper pointer bits pick the 16-bit field
            case (udp_byte_ptr[2:1])
                2'd0: begin
                    if (hi_byte) frame_hdr.udp.src_port[15:8] <= data;
                    else         frame_hdr.udp.src_port[7:0]  <= data;
                end
                2'd1: begin
                    if (hi_byte) frame_hdr.udp.dest_port[15:8] <= data;
                    else         frame_hdr.udp.dest_port[7:0]  <= data;
                end
                2'd2: begin
                    if (hi_byte) frame_hdr.udp.length[15:8] <= data;
                    else         frame_hdr.udp.length[7:0]  <= data;
                end
                default: begin
                    if (hi_byte) frame_hdr.udp.checksum[15:8] <= data;
                    else         frame_hdr.udp.checksum[7:0]  <= data;
                end
            endcase
        end
    end

endmodule

/* design/udp_payload_skid.sv */
// udp_payload_skid: two-entry output register stage with early ready for the payload stream
`timescale 1ns/1ps

module udp_payload_skid (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     in_valid,
    input  udp_rx_pkg::stream_beat_t in_beat,
    output logic                     ready_early,

    output logic                     m_valid,
    input  logic                     m_ready,
    output udp_rx_pkg::stream_beat_t m_beat
);

    // registered copy of ready_early, same timing as the upstream s_ready
    logic in_ready_q;

    logic                     temp_valid_q;
    udp_rx_pkg::stream_beat_t temp_beat_q;

    logic m_valid_next;
    logic temp_valid_next;

    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // next cycle can take a beat unless the temp slot could fill up
    assign ready_early = m_ready || (!temp_valid_q && (!m_valid || !in_valid));

    always_comb begin
        m_valid_next    = m_valid;
        temp_valid_next = temp_valid_q;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;

        if (in_ready_q) begin
            if (m_ready || !m_valid) begin
                // output free or draining
                m_valid_next = in_valid;
                in_to_out    = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next = in_valid;
                in_to_temp      = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next    = temp_valid_q;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_q   <= 1'b0;
            m_valid      <= 1'b0;
            temp_valid_q <= 1'b0;
        end else begin
            in_ready_q   <= ready_early;
            m_valid      <= m_valid_next;
            temp_valid_q <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_beat <= in_beat;
        end else if (temp_to_out) begin
            m_beat <= temp_beat_q;
        end

        if (in_to_temp) begin
            temp_beat_q <= in_beat;
        end
    end

endmodule

/* design/udp_rx_ctrl.sv */
// udp_rx_ctrl: frame FSM, UDP header byte pointer, payload length counter, last-byte hold, errors
`timescale 1ns/1ps

module udp_rx_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     s_hdr_valid,
    output logic                     s_hdr_ready,

    input  logic                     s_valid,
    output logic                     s_ready,
    input  udp_rx_pkg::stream_beat_t s_beat,

    output logic                     m_hdr_valid,
    input  logic                     m_hdr_ready,

    // UDP length as assembled so far
    input  udp_rx_pkg::len16_t       udp_len,

    output logic                     hdr_store,
    output logic                     udp_byte_store,
    output udp_rx_pkg::hdr_ptr_t     udp_byte_ptr,

    output logic                     in_valid,
    output udp_rx_pkg::stream_beat_t in_beat,
    input  logic                     ready_early,

    output logic                     error_header_early,
    output logic                     error_payload_early
);

    localparam udp_rx_pkg::hdr_ptr_t LAST_HDR_PTR =
        udp_rx_pkg::hdr_ptr_t'(udp_rx_pkg::UDP_HDR_BYTES - 1);
    localparam udp_rx_pkg::len16_t HDR_LEN =
        udp_rx_pkg::len16_t'(udp_rx_pkg::UDP_HDR_BYTES);

    udp_rx_pkg::rx_state_t state_q, state_next;
    udp_rx_pkg::hdr_ptr_t  hdr_ptr_q, hdr_ptr_next;
    udp_rx_pkg::len16_t    payload_cnt_q, payload_cnt_next;
    udp_rx_pkg::byte_t     last_data_q;

    logic store_last;
    logic s_hdr_ready_next;
    logic s_ready_next;
    logic m_hdr_valid_next;
    logic err_hdr_next;
    logic err_payload_next;
    logic s_xfer;

    assign s_xfer       = s_valid && s_ready;
    assign udp_byte_ptr = hdr_ptr_q;

    always_comb begin
        state_next       = state_q;
        hdr_ptr_next     = hdr_ptr_q;
        payload_cnt_next = payload_cnt_q;

        s_hdr_ready_next = 1'b0;
        s_ready_next     = 1'b0;
        // header stays up until taken downstream
        m_hdr_valid_next = m_hdr_valid && !m_hdr_ready;
        err_hdr_next     = 1'b0;
        err_payload_next = 1'b0;

        hdr_store      = 1'b0;
        udp_byte_store = 1'b0;
        store_last     = 1'b0;

        in_valid = 1'b0;
        in_beat  = s_beat;

        case (state_q)
            udp_rx_pkg::st_idle: begin
                hdr_ptr_next     = '0;
                // wait for the previous header to drain first
                s_hdr_ready_next = !m_hdr_valid_next;
                if (s_hdr_valid && s_hdr_ready) begin
                    s_hdr_ready_next = 1'b0;
                    s_ready_next     = 1'b1;
                    hdr_store        = 1'b1;
                    state_next       = udp_rx_pkg::st_read_header;
                end
            end

            udp_rx_pkg::st_read_header: begin
                s_ready_next = 1'b1;
                // length bytes land before the last header byte
                payload_cnt_next = udp_len - HDR_LEN;
                if (s_xfer) begin
                    udp_byte_store = 1'b1;
                    hdr_ptr_next   = hdr_ptr_q + 1'b1;
                    if (s_beat.last) begin
                        // frame ended inside the UDP header
                        err_hdr_next     = 1'b1;
                        s_ready_next     = 1'b0;
                        s_hdr_ready_next = !m_hdr_valid_next;
                        state_next       = udp_rx_pkg::st_idle;
                    end else if (hdr_ptr_q == LAST_HDR_PTR) begin
                        m_hdr_valid_next = 1'b1;
                        s_ready_next     = ready_early;
                        state_next       = udp_rx_pkg::st_read_payload;
                    end
                end
            end

            udp_rx_pkg::st_read_payload: begin
                s_ready_next = ready_early;
                if (s_xfer) begin
                    payload_cnt_next = payload_cnt_q - 1'b1;
                    in_valid         = 1'b1;
                    if (s_beat.last) begin
                        if (payload_cnt_q != 16'd1) begin
                            // input ran out before the UDP length
                            in_beat.user     = 1'b1;
                            err_payload_next = 1'b1;
                        end
                        s_ready_next     = 1'b0;
                        s_hdr_ready_next = !m_hdr_valid_next;
                        state_next       = udp_rx_pkg::st_idle;
                    end else if (payload_cnt_q == 16'd1) begin
                        // hold final byte until the input frame ends
                        store_last = 1'b1;
                        in_valid   = 1'b0;
                        state_next = udp_rx_pkg::st_read_payload_last;
                    end
                end
            end

            udp_rx_pkg::st_read_payload_last: begin
                s_ready_next = ready_early;
                // padding is dropped, held byte takes the input's end flags
                in_beat.data = last_data_q;
                if (s_xfer && s_beat.last) begin
                    in_valid         = 1'b1;
                    s_ready_next     = 1'b0;
                    s_hdr_ready_next = !m_hdr_valid_next;
                    state_next       = udp_rx_pkg::st_idle;
                end
            end

            default: begin
                state_next = udp_rx_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q             <= udp_rx_pkg::st_idle;
            hdr_ptr_q           <= '0;
            payload_cnt_q       <= '0;
            s_hdr_ready         <= 1'b0;
            s_ready             <= 1'b0;
            m_hdr_valid         <= 1'b0;
            error_header_early  <= 1'b0;
            error_payload_early <= 1'b0;
        end else begin
            state_q             <= state_next;
            hdr_ptr_q           <= hdr_ptr_next;
            payload_cnt_q       <= payload_cnt_next;
            s_hdr_ready         <= s_hdr_ready_next;
            s_ready             <= s_ready_next;
            m_hdr_valid         <= m_hdr_valid_next;
            error_header_early  <= err_hdr_next;
            error_payload_early <= err_payload_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_data_q <= s_beat.data;
        end
    end

endmodule

/* design/udp_rx_pkg.sv */
// udp_rx_pkg: field typedefs, IP/UDP header structs, stream beat, FSM state enum, constants
package udp_rx_pkg;

    // UDP header length on the wire
    localparam int UDP_HDR_BYTES = 8;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;
    typedef logic [31:0] ipv4_addr_t;

    // index into the eight UDP header bytes
    typedef logic [2:0]  hdr_ptr_t;

    // reduced IP header, only the fields passed through
    typedef struct packed {
        len16_t     ip_length;
        byte_t      protocol;
        ipv4_addr_t src_ip;
        ipv4_addr_t dest_ip;
    } ip_hdr_t;

    // UDP header, fields in wire order
    typedef struct packed {
        port_t  src_port;
        port_t  dest_port;
        len16_t length;
        len16_t checksum;
    } udp_hdr_t;

    // combined header as presented on m_hdr
    typedef struct packed {
        ip_hdr_t  ip;
        udp_hdr_t udp;
    } udp_frame_hdr_t;

    // one byte of a payload stream
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

    // frame FSM states
    typedef enum logic [1:0] {
        st_idle,
        st_read_header,
        st_read_payload,
        st_read_payload_last
    } rx_state_t;

endpackage

/* design/udp_rx_top.sv */
// udp_rx_top: UDP receiver top level joining frame control, header capture and output skid
`timescale 1ns/1ps

module udp_rx_top (
    input  logic                       clk,
    input  logic                       rst,

    // IP header side channel
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  udp_rx_pkg::ip_hdr_t        s_hdr,

    // IP payload stream
    input  logic                       s_valid,
    output logic                       s_ready,
    input  udp_rx_pkg::stream_beat_t   s_beat,

    // combined IP and UDP header out
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output udp_rx_pkg::udp_frame_hdr_t m_hdr,

    // UDP payload stream out
    output logic                       m_valid,
    input  logic                       m_ready,
    output udp_rx_pkg::stream_beat_t   m_beat,

    output logic                       error_header_early,
    output logic                       error_payload_early
);

    // capture controls from the FSM
    logic                     hdr_store;
    logic                     udp_byte_store;
    udp_rx_pkg::hdr_ptr_t     udp_byte_ptr;

    // payload path into the skid buffer
    logic                     in_valid;
    udp_rx_pkg::stream_beat_t in_beat;
    logic                     ready_early;

    udp_rx_ctrl u_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .s_hdr_valid         (s_hdr_valid),
        .s_hdr_ready         (s_hdr_ready),
        .s_valid             (s_valid),
        .s_ready             (s_ready),
        .s_beat              (s_beat),
        .m_hdr_valid         (m_hdr_valid),
        .m_hdr_ready         (m_hdr_ready),
        .udp_len             (m_hdr.udp.length),
        .hdr_store           (hdr_store),
        .udp_byte_store      (udp_byte_store),
        .udp_byte_ptr        (udp_byte_ptr),
        .in_valid            (in_valid),
        .in_beat             (in_beat),
        .ready_early         (ready_early),
        .error_header_early  (error_header_early),
        .error_payload_early (error_payload_early)
    );

    udp_hdr_capture u_hdr_capture (
        .clk            (clk),
        .s_hdr          (s_hdr),
        .hdr_store      (hdr_store),
        .data           (s_beat.data),
        .udp_byte_store (udp_byte_store),
        .udp_byte_ptr   (udp_byte_ptr),
        .frame_hdr      (m_hdr)
    );

    udp_payload_skid u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .ready_early (ready_early),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_beat      (m_beat)
    );

endmodule

/* src.f */
+incdir+testbench
design/udp_rx_pkg.sv
design/udp_hdr_capture.sv
design/udp_payload_skid.sv
design/udp_rx_ctrl.sv
design/udp_rx_top.sv
testbench/tb_udp_rx.sv

/* testbench/tb_udp_rx_util.svh */
// LFSR step and random bits, frame builder and reference model for the UDP receiver testbench
`ifndef TB_UDP_RX_UTIL_SVH
`define TB_UDP_RX_UTIL_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        data_lfsr = lfsr_step(data_lfsr);
        v = {v[30:0], data_lfsr[0]};
    end
    return v;
endfunction

// random IP and UDP fields, n_bytes of payload into tx_payload
function automatic udp_rx_pkg::udp_hdr_t build_frame(input int n_bytes, input int udp_payload_len,
                                                     output udp_rx_pkg::ip_hdr_t ip);
    udp_rx_pkg::udp_hdr_t udp;
    ip.ip_length  = 16'(28 + n_bytes);
    ip.protocol   = 8'd17;
    ip.src_ip     = rand_bits(32);
    ip.dest_ip    = rand_bits(32);
    udp.src_port  = 16'(rand_bits(16));
    udp.dest_port = 16'(rand_bits(16));
    udp.length    = 16'(udp_payload_len + 8);
    udp.checksum  = 16'(rand_bits(16));
    tx_payload.delete();
    for (int i = 0; i < n_bytes; i++) begin
        tx_payload.push_back(8'(rand_bits(8)));
    end
    return udp;
endfunction

// expected header, beats into exp_beats, and whether the frame is short
function automatic udp_rx_pkg::udp_frame_hdr_t predict_frame(
        input udp_rx_pkg::ip_hdr_t ip, input udp_rx_pkg::udp_hdr_t udp,
        input udp_rx_pkg::byte_t payload[$], output logic short_frame);
    udp_rx_pkg::udp_frame_hdr_t h;
    udp_rx_pkg::stream_beat_t b;
    int count;
    int keep;
    h.ip  = ip;
    h.udp = udp;
    count = int'(udp.length) - 8;
    short_frame = payload.size() < count;
    keep = short_frame ? payload.size() : count;
    exp_beats.delete();
    for (int i = 0; i < keep; i++) begin
        b.data = payload[i];
        b.last = (i == keep - 1);
        b.user = (i == keep - 1) && short_frame;
        exp_beats.push_back(b);
    end
    return h;
endfunction

`endif

/* testbench/tb_udp_rx.sv */
// testbench top with clock, reset, DUT, frame driver, output monitor, checks and reporting
`timescale 1ns/1ps

module tb_udp_rx;

    localparam int TIMEOUT = 2000;

    logic clk = 1'b0;
    logic rst;
    logic s_hdr_valid;
    logic s_hdr_ready;
    udp_rx_pkg::ip_hdr_t s_hdr;
    logic s_valid;
    logic s_ready;
    udp_rx_pkg::stream_beat_t s_beat;
    logic m_hdr_valid;
    logic m_hdr_ready = 1'b1;
    udp_rx_pkg::udp_frame_hdr_t m_hdr;
    logic m_valid;
    logic m_ready = 1'b1;
    udp_rx_pkg::stream_beat_t m_beat;
    logic error_header_early;
    logic error_payload_early;

    logic [15:0] data_lfsr = 16'd42;
    logic [15:0] ready_lfsr = 16'd42;
    logic bp_en = 1'b0;

    udp_rx_pkg::byte_t tx_payload[$];
    udp_rx_pkg::stream_beat_t exp_beats[$];
    udp_rx_pkg::udp_frame_hdr_t got_hdrs[$];
    udp_rx_pkg::stream_beat_t got_beats[$];
    logic err_hdr_seen = 1'b0;
    logic err_pay_seen = 1'b0;

    int test_errors = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "tb_udp_rx_util.svh"

    udp_rx_top DUT (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready), .s_hdr(s_hdr),
        .s_valid(s_valid), .s_ready(s_ready), .s_beat(s_beat),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready), .m_hdr(m_hdr),
        .m_valid(m_valid), .m_ready(m_ready), .m_beat(m_beat),
        .error_header_early(error_header_early), .error_payload_early(error_payload_early)
    );

    always #10 clk = ~clk;

    // random back-pressure on both outputs
    always @(negedge clk) begin
        if (bp_en) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            m_ready = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            m_hdr_ready = ready_lfsr[0];
        end else begin
            m_ready = 1'b1;
            m_hdr_ready = 1'b1;
        end
    end

    // output monitor with sticky error pulses
    always @(posedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) got_hdrs.push_back(m_hdr);
            if (m_valid && m_ready) got_beats.push_back(m_beat);
            if (error_header_early) err_hdr_seen = 1'b1;
            if (error_payload_early) err_pay_seen = 1'b1;
        end
    end

    task automatic send_header(input udp_rx_pkg::ip_hdr_t ip);
        int t;
        logic taken;
        s_hdr_valid = 1'b1;
        s_hdr = ip;
        t = 0;
        taken = 1'b0;
        while (!taken && t < TIMEOUT) begin
            taken = s_hdr_ready;
            @(negedge clk);
            t++;
        end
        s_hdr_valid = 1'b0;
        if (!taken) begin
            $display("timeout: IP header was never accepted");
            test_errors++;
        end
    endtask

    task automatic send_byte(input udp_rx_pkg::byte_t d, input logic last);
        int t;
        logic taken;
        s_valid = 1'b1;
        s_beat.data = d;
        s_beat.last = last;
        s_beat.user = 1'b0;
        t = 0;
        taken = 1'b0;
        while (!taken && t < TIMEOUT) begin
            taken = s_ready;
            @(negedge clk);
            t++;
        end
        if (!taken) begin
            $display("timeout: payload byte was never accepted");
            test_errors++;
        end
    endtask

    // hdr_cut above zero ends the frame inside the UDP header
    task automatic send_frame(input udp_rx_pkg::ip_hdr_t ip, input udp_rx_pkg::udp_hdr_t udp,
                              input int hdr_cut);
        udp_rx_pkg::byte_t bytes[$];
        int n_send;
        for (int i = 0; i < 8; i++) bytes.push_back(udp[63 - 8 * i -: 8]);
        foreach (tx_payload[i]) bytes.push_back(tx_payload[i]);
        n_send = (hdr_cut > 0) ? hdr_cut : bytes.size();
        send_header(ip);
        for (int i = 0; i < n_send; i++) begin
            if (bp_en && rand_bits(1)) begin
                s_valid = 1'b0;
                @(negedge clk);
            end
            send_byte(bytes[i], i == n_send - 1);
        end
        s_valid = 1'b0;
    endtask

    task automatic wait_frame_done();
        int t;
        t = 0;
        while (!(got_hdrs.size() > 0 && got_beats.size() > 0 && got_beats[$].last)
               && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("timeout: frame never completed on the output");
            test_errors++;
        end
    endtask

    task automatic check_frame(input string name, input udp_rx_pkg::ip_hdr_t ip,
                               input udp_rx_pkg::udp_hdr_t udp);
        udp_rx_pkg::udp_frame_hdr_t exp_hdr;
        logic exp_short;
        exp_hdr = predict_frame(ip, udp, tx_payload, exp_short);
        if (got_hdrs.size() != 1) begin
            $display("error %s hdr count: expected 1 actual %0d", name, got_hdrs.size());
            test_errors++;
        end else if (got_hdrs[0] != exp_hdr) begin
            $display("error %s m_hdr: expected %h actual %h", name, exp_hdr, got_hdrs[0]);
            test_errors++;
        end
        if (got_beats.size() != exp_beats.size()) begin
            $display("error %s beat count: expected %0d actual %0d", name,
                     exp_beats.size(), got_beats.size());
            test_errors++;
        end else begin
            foreach (exp_beats[i]) begin
                if (got_beats[i] != exp_beats[i]) begin
                    $display("error %s beat %0d: expected %h actual %h", name, i,
                             exp_beats[i], got_beats[i]);
                    test_errors++;
                end
            end
        end
        if (err_pay_seen != exp_short) begin
            $display("error %s payload error: expected %b actual %b", name, exp_short,
                     err_pay_seen);
            test_errors++;
        end
        if (err_hdr_seen) begin
            $display("error %s header error: expected 0 actual 1", name);
            test_errors++;
        end
        got_hdrs.delete();
        got_beats.delete();
        err_hdr_seen = 1'b0;
        err_pay_seen = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        udp_rx_pkg::ip_hdr_t ip;
        udp_rx_pkg::udp_hdr_t udp;
        int t;
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        s_hdr = '0;
        s_valid = 1'b0;
        s_beat = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        udp = build_frame(12, 12, ip);
        send_frame(ip, udp, 0);
        wait_frame_done();
        check_frame("exact", ip, udp);
        finish_test("exact");

        // five padding bytes past the UDP length
        udp = build_frame(15, 10, ip);
        send_frame(ip, udp, 0);
        wait_frame_done();
        check_frame("padded", ip, udp);
        finish_test("padded");

        udp = build_frame(7, 20, ip);
        send_frame(ip, udp, 0);
        wait_frame_done();
        check_frame("short", ip, udp);
        finish_test("short");

        // tlast on the fifth UDP header byte
        udp = build_frame(4, 4, ip);
        send_frame(ip, udp, 5);
        t = 0;
        while (!(err_hdr_seen && s_hdr_ready) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("timeout: header error never reported after truncated header");
            test_errors++;
        end
        if (got_hdrs.size() != 0 || got_beats.size() != 0) begin
            $display("truncated header still produced output on m_hdr or m_beat");
            test_errors++;
        end
        got_hdrs.delete();
        got_beats.delete();
        err_hdr_seen = 1'b0;
        udp = build_frame(6, 6, ip);
        send_frame(ip, udp, 0);
        wait_frame_done();
        check_frame("trunc_header", ip, udp);
        finish_test("trunc_header");

        bp_en = 1'b1;
        for (int f = 0; f < 6; f++) begin
            udp = build_frame(1 + int'(rand_bits(5)), 1 + int'(rand_bits(5)), ip);
            send_frame(ip, udp, 0);
            wait_frame_done();
            check_frame("backpressure", ip, udp);
        end
        bp_en = 1'b0;
        finish_test("backpressure");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
